// File: src/dbg_bus_pkg.sv
/*
 * Debug bus definitions
 * Data width, byte-offset width, address region decode and the
 * AXI-lite write payload shared by the debug slave.
 */
`default_nettype none

package dbg_bus_pkg;

	// Debug bus is always one 32-bit word wide
	localparam int DBG_DATA_WIDTH = 32;
	// Byte offset bits below the word index
	localparam int DBG_LSB = $clog2(DBG_DATA_WIDTH / 8);

	// Word index bit 5 picks the region
	typedef enum logic
	{
		DBG_REGION_REG = 1'b0,
		DBG_REGION_CTRL = 1'b1
	} dbg_region_e;

	// Write data beat, data and byte strobes
	typedef struct packed
	{
		logic [DBG_DATA_WIDTH-1:0] data;
		logic [DBG_DATA_WIDTH/8-1:0] strb;
	} dbg_w_t;

endpackage

`default_nettype wire

// File: src/cpu_ctrl_pkg.sv
/*
 * CPU run-control definitions
 * Control word bit positions, the status word layout and the
 * request and response structs of the CPU debug port.
 */
`default_nettype none

package cpu_ctrl_pkg;

	// Control word command bits
	localparam int RESET_BIT = 6;
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Status word, MSB first
	typedef struct packed
	{
		logic [14:0] rsvd_hi;
		logic interrupt;
		logic rsvd_15;
		logic brk;
		logic [2:0] cc;
		logic halt;
		// Halted is simply "CPU not stalled"
		logic halted;
		logic rsvd_8;
		logic int_pending;
		logic reset;
		logic [5:0] rsvd_lo;
	} cpu_status_t;

	// Levels toward the CPU
	typedef struct packed
	{
		logic halt;
		logic reset;
		logic clear_cache;
		logic we;
		logic [4:0] wreg;
		logic [31:0] wdata;
		logic [4:0] rreg;
	} cpu_dbg_req_t;

	// Levels back from the CPU
	typedef struct packed
	{
		logic stall;
		logic brk;
		logic [2:0] cc;
		logic [31:0] rdata;
	} cpu_dbg_rsp_t;

endpackage

`default_nettype wire

// File: src/dbg_skid_buffer.sv
/*
 * Skid buffer for one bus channel
 * Passes beats straight through while empty; parks one beat
 * when downstream stalls and drops ready until it drains.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_skid_buffer #(
	parameter int DW = 8
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Upstream side
	input wire i_valid,
	output logic o_ready,
	input wire logic [DW-1:0] i_data,
	// Downstream side
	output logic o_valid,
	input wire i_ready,
	output logic [DW-1:0] o_data
);

	logic r_valid;
	logic [DW-1:0] r_data;

	// Park a beat when it arrives and downstream refuses it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Payload follows the input while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	assign o_ready = !r_valid;
	assign o_valid = i_valid || r_valid;
	// Stored beat goes first
	assign o_data = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

// File: src/dbg_axil_port.sv
/*
 * AXI-lite debug port
 * Accepts host writes and reads, forwards register-window writes
 * and reads to the CPU and returns the status word otherwise.
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_axil_port
	import dbg_bus_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter int C_DBG_ADDR_WIDTH = 8
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Host write channels
	input wire i_dbg_awvalid,
	output logic o_dbg_awready,
	input wire logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_awaddr,
	input wire i_dbg_wvalid,
	output logic o_dbg_wready,
	input wire dbg_w_t i_dbg_w,
	output logic o_dbg_bvalid,
	input wire i_dbg_bready,
	// Host read channels
	input wire i_dbg_arvalid,
	output logic o_dbg_arready,
	input wire logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_araddr,
	output logic o_dbg_rvalid,
	input wire i_dbg_rready,
	output logic [DBG_DATA_WIDTH-1:0] o_dbg_rdata,
	// CPU side
	output cpu_dbg_req_t o_cpu_wr,
	output logic [4:0] o_cpu_rreg,
	input wire cpu_dbg_rsp_t i_cpu_rsp,
	input wire cpu_status_t i_status,
	// Toward run control
	output logic o_ctrl_wr,
	output dbg_w_t o_ctrl_data,
	output logic o_reg_wr,
	output logic o_reg_wr_pending
);

	// Word index width
	localparam int AIW = C_DBG_ADDR_WIDTH - DBG_LSB;

	logic awskd_valid, wskd_valid, arskd_valid;
	logic [AIW-1:0] awskd_addr, arskd_addr;
	dbg_w_t wskd_w;
	dbg_region_e aw_region, ar_region;
	logic write_ready, read_ready;
	logic wr_pending;
	logic [4:0] wr_reg;
	logic [31:0] wr_data;
	logic rd_inflight;
	logic [4:0] rd_reg;

	////////////////////////////////////////
	// Write path
	////////////////////////////////////////

	dbg_skid_buffer #(.DW(AIW)) aw_skid_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_awvalid),
		.o_ready(o_dbg_awready),
		.i_data(i_dbg_awaddr[C_DBG_ADDR_WIDTH-1:DBG_LSB]),
		.o_valid(awskd_valid),
		.i_ready(write_ready),
		.o_data(awskd_addr)
	);

	dbg_skid_buffer #(.DW($bits(dbg_w_t))) w_skid_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_wvalid),
		.o_ready(o_dbg_wready),
		.i_data(i_dbg_w),
		.o_valid(wskd_valid),
		.i_ready(write_ready),
		.o_data(wskd_w)
	);

	assign aw_region = dbg_region_e'(awskd_addr[5]);

	// Register writes wait while an earlier one is still stuck
	assign write_ready = awskd_valid && wskd_valid
		&& (aw_region == DBG_REGION_CTRL || wskd_w.strb == '0
			|| !wr_pending || !i_cpu_rsp.stall)
		&& (!o_dbg_bvalid || i_dbg_bready);

	// Pending register write, held until the CPU stops stalling
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_pending <= 1'b0;
		else if (!wr_pending || !i_cpu_rsp.stall)
			wr_pending <= write_ready && (|wskd_w.strb)
				&& aw_region == DBG_REGION_REG;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!wr_pending || !i_cpu_rsp.stall)
		begin
			wr_reg <= awskd_addr[4:0];
			wr_data <= wskd_w.data;
		end
	end

	// B channel, response is always OKAY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_bvalid <= 1'b0;
		else if (write_ready)
			o_dbg_bvalid <= 1'b1;
		else if (i_dbg_bready)
			o_dbg_bvalid <= 1'b0;
	end

	// Halt/reset/clear-cache get filled in at the top
	always_comb
	begin
		o_cpu_wr = '0;
		o_cpu_wr.we = wr_pending;
		o_cpu_wr.wreg = wr_reg;
		o_cpu_wr.wdata = wr_data;
	end

	assign o_ctrl_wr = write_ready && aw_region == DBG_REGION_CTRL;
	assign o_ctrl_data = wskd_w;
	assign o_reg_wr = write_ready && aw_region == DBG_REGION_REG && (|wskd_w.strb);
	assign o_reg_wr_pending = wr_pending;

	////////////////////////////////////////
	// Read path
	////////////////////////////////////////

	dbg_skid_buffer #(.DW(AIW)) ar_skid_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_arvalid),
		.o_ready(o_dbg_arready),
		.i_data(i_dbg_araddr[C_DBG_ADDR_WIDTH-1:DBG_LSB]),
		.o_valid(arskd_valid),
		.i_ready(read_ready),
		.o_data(arskd_addr)
	);

	assign ar_region = dbg_region_e'(arskd_addr[5]);
	assign read_ready = arskd_valid && !rd_inflight
		&& (!o_dbg_rvalid || i_dbg_rready);

	// Register read takes one extra cycle through the CPU
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_inflight <= 1'b0;
		else
			rd_inflight <= read_ready && ar_region == DBG_REGION_REG;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (read_ready)
			rd_reg <= arskd_addr[4:0];
	end

	// Keep the index steady until the data is captured
	assign o_cpu_rreg = rd_inflight ? rd_reg : arskd_addr[4:0];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_rvalid <= 1'b0;
		else if (!o_dbg_rvalid || i_dbg_rready)
			o_dbg_rvalid <= (read_ready && ar_region == DBG_REGION_CTRL)
				|| rd_inflight;
	end

	// Holds while R is stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_dbg_rvalid || i_dbg_rready)
			o_dbg_rdata <= rd_inflight ? i_cpu_rsp.rdata : i_status;
	end

endmodule

`default_nettype wire

// File: src/cpu_run_ctrl.sv
/*
 * CPU run control
 * Start-up reset hold, halt/step/reset/clear-cache command
 * registers and the status word returned to the host.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_run_ctrl
	import dbg_bus_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_cpu_reset,
	input wire i_interrupt,
	// Commands from the bus port
	input wire i_ctrl_wr,
	input wire dbg_w_t i_ctrl_data,
	input wire i_reg_wr,
	input wire i_reg_wr_pending,
	input wire cpu_dbg_rsp_t i_cpu_rsp,
	// Levels to the CPU
	output logic o_halt,
	output logic o_reset,
	output logic o_clear_cache,
	output cpu_status_t o_status
);

	localparam int CW = $clog2(RESET_DURATION + 1);

	logic [CW-1:0] reset_counter;
	logic reset_hold;
	logic cmd_halt, cmd_reset, cmd_step, cmd_clear_cache;
	logic halt_byte_wr;

	////////////////////////////////////////
	// Reset hold
	////////////////////////////////////////

	// Restarts on bus reset or an external CPU reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_counter <= CW'(RESET_DURATION);
		else if (reset_counter != '0)
			reset_counter <= reset_counter - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_hold <= 1'b1;
		else
			reset_hold <= (reset_counter > 1);
	end

	////////////////////////////////////////
	// Command registers
	////////////////////////////////////////

	// Halt, step and clear-cache live in byte 1
	assign halt_byte_wr = i_ctrl_wr && i_ctrl_data.strb[1];

	// CPU reset, one cycle per reset write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset || reset_hold)
			cmd_reset <= 1'b1;
		else if (i_cpu_rsp.brk && !START_HALTED)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= i_ctrl_wr && i_ctrl_data.strb[0]
				&& i_ctrl_data.data[RESET_BIT];
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_halt <= START_HALTED;
		else if (cmd_reset && START_HALTED)
			cmd_halt <= 1'b1;
		else
		begin
			// Release only once the CPU is quiet
			if (!i_reg_wr_pending && !i_cpu_rsp.stall && halt_byte_wr
				&& (!i_ctrl_data.data[HALT_BIT] || i_ctrl_data.data[STEP_BIT]))
				cmd_halt <= 1'b0;
			// Break halts when the CPU starts halted
			if (i_cpu_rsp.brk && START_HALTED)
				cmd_halt <= 1'b1;
			// Plain halt request, step wins over it
			if (halt_byte_wr && i_ctrl_data.data[HALT_BIT]
				&& !i_ctrl_data.data[STEP_BIT])
				cmd_halt <= 1'b1;
			// Register access needs a stopped CPU
			if (i_reg_wr)
				cmd_halt <= 1'b1;
			if (cmd_step || cmd_clear_cache)
				cmd_halt <= 1'b1;
			if (halt_byte_wr && i_ctrl_data.data[CLEAR_CACHE_BIT])
				cmd_halt <= 1'b1;
		end
	end

	// Step lasts until the CPU has moved
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (halt_byte_wr && i_ctrl_data.data[STEP_BIT])
			cmd_step <= 1'b1;
		else if (!i_cpu_rsp.stall)
			cmd_step <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (halt_byte_wr && i_ctrl_data.data[CLEAR_CACHE_BIT]
			&& i_ctrl_data.data[HALT_BIT])
			cmd_clear_cache <= 1'b1;
		else if (cmd_halt && !i_cpu_rsp.stall)
			cmd_clear_cache <= 1'b0;
	end

	assign o_halt = cmd_halt;
	assign o_reset = cmd_reset;
	assign o_clear_cache = cmd_clear_cache;

	// Status word, unused bits read zero
	always_comb
	begin
		o_status = '0;
		o_status.interrupt = i_interrupt;
		o_status.brk = i_cpu_rsp.brk;
		o_status.cc = i_cpu_rsp.cc;
		o_status.halt = cmd_halt;
		o_status.halted = !i_cpu_rsp.stall;
		o_status.int_pending = i_interrupt;
		o_status.reset = cmd_reset;
	end

endmodule

`default_nettype wire

// File: src/cpu_dbg_top.sv
/*
 * CPU debug front end
 * Joins the AXI-lite debug port with run control and drives
 * the CPU debug request.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_dbg_top
	import dbg_bus_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter int C_DBG_ADDR_WIDTH = 8,
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_interrupt,
	input wire i_cpu_reset,
	// Host channels
	input wire i_dbg_awvalid,
	output logic o_dbg_awready,
	input wire logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_awaddr,
	input wire i_dbg_wvalid,
	output logic o_dbg_wready,
	input wire dbg_w_t i_dbg_w,
	output logic o_dbg_bvalid,
	input wire i_dbg_bready,
	input wire i_dbg_arvalid,
	output logic o_dbg_arready,
	input wire logic [C_DBG_ADDR_WIDTH-1:0] i_dbg_araddr,
	output logic o_dbg_rvalid,
	input wire i_dbg_rready,
	output logic [DBG_DATA_WIDTH-1:0] o_dbg_rdata,
	// CPU debug port
	output cpu_dbg_req_t o_cpu_req,
	input wire cpu_dbg_rsp_t i_cpu_rsp,
	output logic o_cmd_reset
);

	cpu_dbg_req_t port_wr;
	logic [4:0] cpu_rreg;
	cpu_status_t status;
	logic ctrl_wr, reg_wr, reg_wr_pending;
	dbg_w_t ctrl_data;
	logic cmd_halt, cmd_reset, cmd_clear_cache;

	dbg_axil_port #(.C_DBG_ADDR_WIDTH(C_DBG_ADDR_WIDTH)) axil_port_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_dbg_awvalid(i_dbg_awvalid),
		.o_dbg_awready(o_dbg_awready),
		.i_dbg_awaddr(i_dbg_awaddr),
		.i_dbg_wvalid(i_dbg_wvalid),
		.o_dbg_wready(o_dbg_wready),
		.i_dbg_w(i_dbg_w),
		.o_dbg_bvalid(o_dbg_bvalid),
		.i_dbg_bready(i_dbg_bready),
		.i_dbg_arvalid(i_dbg_arvalid),
		.o_dbg_arready(o_dbg_arready),
		.i_dbg_araddr(i_dbg_araddr),
		.o_dbg_rvalid(o_dbg_rvalid),
		.i_dbg_rready(i_dbg_rready),
		.o_dbg_rdata(o_dbg_rdata),
		.o_cpu_wr(port_wr),
		.o_cpu_rreg(cpu_rreg),
		.i_cpu_rsp(i_cpu_rsp),
		.i_status(status),
		.o_ctrl_wr(ctrl_wr),
		.o_ctrl_data(ctrl_data),
		.o_reg_wr(reg_wr),
		.o_reg_wr_pending(reg_wr_pending)
	);

	cpu_run_ctrl #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) run_ctrl_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset),
		.i_interrupt(i_interrupt),
		.i_ctrl_wr(ctrl_wr),
		.i_ctrl_data(ctrl_data),
		.i_reg_wr(reg_wr),
		.i_reg_wr_pending(reg_wr_pending),
		.i_cpu_rsp(i_cpu_rsp),
		.o_halt(cmd_halt),
		.o_reset(cmd_reset),
		.o_clear_cache(cmd_clear_cache),
		.o_status(status)
	);

	// Write fields from the port, commands from run control
	always_comb
	begin
		o_cpu_req = port_wr;
		o_cpu_req.halt = cmd_halt;
		o_cpu_req.reset = cmd_reset;
		o_cpu_req.clear_cache = cmd_clear_cache;
		o_cpu_req.rreg = cpu_rreg;
	end

	assign o_cmd_reset = cmd_reset;

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 4 ns clock, active-low reset held for 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#2 o_clk = ~o_clk;
	end

	// Release on a falling edge, like the other stimulus
	initial
	begin
		o_rst_n = 1'b0;
		repeat (3) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/tb_dbg_checker.sv
/*
 * Testbench checker
 * Watches the DUT outputs, compares them with the expected
 * values of the current row, counts and reports per row.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_checker
	import cpu_ctrl_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	// DUT outputs under watch
	input wire i_bvalid,
	input wire i_rvalid,
	input wire i_rready,
	input wire logic [31:0] i_rdata,
	input wire i_cmd_reset,
	input wire cpu_dbg_req_t i_cpu_req,
	input wire i_stall,
	// Row control from the stimulus side
	input wire i_row_start,
	input wire i_row_done,
	input wire logic [7:0] i_row_idx,
	input wire logic [95:0] i_row_name,
	input wire i_chk_read,
	input wire i_chk_write,
	input wire i_chk_reset,
	input wire logic [31:0] i_exp_value,
	input wire logic [4:0] i_exp_wreg,
	output int o_checks,
	output int o_errors,
	output int o_rows
);

	logic prev_reset = 1'b1;
	logic in_reset = 1'b1;
	logic read_seen = 1'b0;
	logic write_seen = 1'b0;
	logic row_fail = 1'b0;
	int falls = 0;
	int last_falls = 0;

	initial
	begin
		o_checks = 0;
		o_errors = 0;
		o_rows = 0;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		o_checks++;
		if (got !== exp)
		begin
			o_errors++;
			row_fail = 1'b1;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		o_errors++;
		row_fail = 1'b1;
		$display("[ERROR] %0t row %0d: %s", $time, i_row_idx, what);
	endtask

	// Closing checks of a row, then its summary line
	task automatic finish_row();
		if (i_chk_read && !read_seen)
			report_failure("no read response came back");
		if (i_chk_write && !write_seen)
			report_failure("CPU never saw the register write");
		if (i_chk_reset)
		begin
			// Request field follows the CPU reset level
			check_value("o_cpu_req.reset", i_cpu_req.reset, 32'd0);
			if (falls == last_falls)
				report_failure("o_cmd_reset did not pulse");
			last_falls = falls;
		end
		// No row asks for a cache clear
		check_value("o_cpu_req.clear_cache", i_cpu_req.clear_cache, 32'd0);
		o_rows++;
		if (row_fail)
			$display("row %0d %0s: FAILED", i_row_idx, i_row_name);
		else
			$display("row %0d %0s: ok", i_row_idx, i_row_name);
	endtask

	always @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			prev_reset = 1'b1;
			in_reset = 1'b1;
		end
		else
		begin
			// First cycle out of reset
			if (in_reset)
			begin
				check_value("o_dbg_bvalid", i_bvalid, 32'd0);
				check_value("o_dbg_rvalid", i_rvalid, 32'd0);
				check_value("o_cmd_reset", i_cmd_reset, 32'd1);
				check_value("o_cpu_req.reset", i_cpu_req.reset, 32'd1);
				in_reset = 1'b0;
			end
			// Count falling edges of the CPU reset
			if (prev_reset && !i_cmd_reset)
				falls++;
			prev_reset = i_cmd_reset;
			if (i_row_start)
			begin
				read_seen = 1'b0;
				write_seen = 1'b0;
				row_fail = 1'b0;
			end
			// R handshake
			if (i_rvalid && i_rready)
			begin
				read_seen = 1'b1;
				if (i_chk_read)
					check_value("o_dbg_rdata", i_rdata, i_exp_value);
			end
			// Register write lands in the CPU
			if (i_cpu_req.we && !i_stall)
			begin
				write_seen = 1'b1;
				if (i_chk_write)
				begin
					check_value("o_cpu_req.wreg", 32'(i_cpu_req.wreg), 32'(i_exp_wreg));
					check_value("o_cpu_req.wdata", i_cpu_req.wdata, i_exp_value);
				end
			end
			if (i_row_done)
				finish_row();
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_cpu_dbg.sv
/*
 * Testbench for the CPU debug front end
 * Table-driven host accesses, a small CPU model on the debug
 * port and a watchdog on the cycle count.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_dbg
	import dbg_bus_pkg::*;
	import cpu_ctrl_pkg::*;
;

	localparam int RESET_DURATION = 10;
	localparam int N_ROWS = 21;
	localparam int TIMEOUT_CYCLES = N_ROWS * 40 + RESET_DURATION + 20;
	// Row operations
	localparam int OP_CTRL_WR = 0;
	localparam int OP_REG_WR = 1;
	localparam int OP_STATUS_RD = 2;
	localparam int OP_REG_RD = 3;
	localparam int OP_BREAK = 4;
	localparam int OP_EXPECT_RESET = 5;
	localparam logic [7:0] CTRL_ADDR = 8'h80;

	logic clk, rst_n;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [7:0] awaddr, araddr;
	dbg_w_t dbg_w;
	logic [31:0] rdata;
	logic interrupt, cpu_reset, cmd_reset;
	cpu_dbg_req_t cpu_req;
	cpu_dbg_rsp_t cpu_rsp;

	// CPU model state
	logic stall, brk;
	logic [31:0] cpu_regs [32];

	// Stimulus table
	int t_op [N_ROWS];
	logic [7:0] t_addr [N_ROWS];
	logic [31:0] t_data [N_ROWS];
	logic [3:0] t_strb [N_ROWS];
	int t_hold [N_ROWS];
	logic [31:0] t_exp [N_ROWS];
	int n_loaded;

	// Row control toward the checker
	logic row_start, row_done, chk_read, chk_write, chk_reset;
	logic [7:0] row_idx;
	logic [95:0] row_name;
	logic [31:0] exp_value;
	logic [4:0] exp_wreg;
	int checks, errors, rows;
	int cycles;

	tb_clk_gen clk_gen_i (
		.o_clk(clk),
		.o_rst_n(rst_n)
	);

	cpu_dbg_top #(
		.C_DBG_ADDR_WIDTH(8),
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(1'b0)
	) cpu_dbg_top_i (
		.S_AXI_ACLK(clk),
		.S_AXI_ARESETN(rst_n),
		.i_interrupt(interrupt),
		.i_cpu_reset(cpu_reset),
		.i_dbg_awvalid(awvalid),
		.o_dbg_awready(awready),
		.i_dbg_awaddr(awaddr),
		.i_dbg_wvalid(wvalid),
		.o_dbg_wready(wready),
		.i_dbg_w(dbg_w),
		.o_dbg_bvalid(bvalid),
		.i_dbg_bready(bready),
		.i_dbg_arvalid(arvalid),
		.o_dbg_arready(arready),
		.i_dbg_araddr(araddr),
		.o_dbg_rvalid(rvalid),
		.i_dbg_rready(rready),
		.o_dbg_rdata(rdata),
		.o_cpu_req(cpu_req),
		.i_cpu_rsp(cpu_rsp),
		.o_cmd_reset(cmd_reset)
	);

	tb_dbg_checker checker_i (
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_bvalid(bvalid),
		.i_rvalid(rvalid),
		.i_rready(rready),
		.i_rdata(rdata),
		.i_cmd_reset(cmd_reset),
		.i_cpu_req(cpu_req),
		.i_stall(stall),
		.i_row_start(row_start),
		.i_row_done(row_done),
		.i_row_idx(row_idx),
		.i_row_name(row_name),
		.i_chk_read(chk_read),
		.i_chk_write(chk_write),
		.i_chk_reset(chk_reset),
		.i_exp_value(exp_value),
		.i_exp_wreg(exp_wreg),
		.o_checks(checks),
		.o_errors(errors),
		.o_rows(rows)
	);

	////////////////////////////////////////
	// CPU model
	////////////////////////////////////////

	// Running CPU stalls the debug port
	always @(posedge clk)
	begin
		stall <= !cpu_req.halt;
		if (cpu_req.we && !stall)
			cpu_regs[cpu_req.wreg] <= cpu_req.wdata;
	end

	always_comb
	begin
		cpu_rsp.stall = stall;
		cpu_rsp.brk = brk;
		cpu_rsp.cc = 3'b000;
		cpu_rsp.rdata = cpu_regs[cpu_req.rreg];
	end

	// Watchdog
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Table and bus tasks
	////////////////////////////////////////

	task automatic add_row(input int op, input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int hold, input logic [31:0] exp);
		t_op[n_loaded] = op;
		t_addr[n_loaded] = addr;
		t_data[n_loaded] = data;
		t_strb[n_loaded] = strb;
		t_hold[n_loaded] = hold;
		t_exp[n_loaded] = exp;
		n_loaded++;
	endtask

	// Expected status word, halt at bit 10 and halted at bit 9
	function automatic logic [31:0] status_word(input logic halt, input logic halted);
		return (32'(halt) << 10) | (32'(halted) << 9);
	endfunction

	function automatic logic [95:0] op_name(input int op);
		case (op)
			OP_CTRL_WR: return "ctrl_write";
			OP_REG_WR: return "reg_write";
			OP_STATUS_RD: return "status_read";
			OP_REG_RD: return "reg_read";
			OP_BREAK: return "pulse_break";
			default: return "expect_reset";
		endcase
	endfunction

	task automatic load_table();
		n_loaded = 0;
		add_row(OP_EXPECT_RESET, 8'h00, 32'h0, 4'h0, 0, 32'h0);
		add_row(OP_STATUS_RD, CTRL_ADDR, 32'h0, 4'h0, 0, status_word(0, 0));
		add_row(OP_CTRL_WR, CTRL_ADDR, 32'h1 << 10, 4'b0010, 0, 32'h0);
		add_row(OP_STATUS_RD, CTRL_ADDR, 32'h0, 4'h0, 0, status_word(1, 1));
		add_row(OP_REG_WR, 8'd5 << 2, 32'hcafe_0005, 4'hf, 0, 32'hcafe_0005);
		add_row(OP_REG_RD, 8'd5 << 2, 32'h0, 4'h0, 0, 32'hcafe_0005);
		// Untouched register keeps its seeded value
		add_row(OP_REG_RD, 8'd7 << 2, 32'h0, 4'h0, 2, cpu_regs[7]);
		add_row(OP_CTRL_WR, CTRL_ADDR, 32'h1 << 8, 4'b0010, 0, 32'h0);
		add_row(OP_STATUS_RD, CTRL_ADDR, 32'h0, 4'h0, 0, status_word(1, 1));
		add_row(OP_CTRL_WR, CTRL_ADDR, 32'h1 << 6, 4'b0001, 0, 32'h0);
		add_row(OP_EXPECT_RESET, 8'h00, 32'h0, 4'h0, 0, 32'h0);
		add_row(OP_STATUS_RD, CTRL_ADDR, 32'h0, 4'h0, 0, status_word(1, 1));
		add_row(OP_BREAK, 8'h00, 32'h0, 4'h0, 0, 32'h0);
		add_row(OP_EXPECT_RESET, 8'h00, 32'h0, 4'h0, 0, 32'h0);
		add_row(OP_CTRL_WR, CTRL_ADDR, 32'h0, 4'b0010, 0, 32'h0);
		add_row(OP_STATUS_RD, CTRL_ADDR, 32'h0, 4'h0, 0, status_word(0, 0));
		// B held off by the host
		add_row(OP_REG_WR, 8'd9 << 2, 32'h1234_5609, 4'hf, 5, 32'h1234_5609);
		add_row(OP_REG_WR, 8'd10 << 2, 32'ha5a5_000a, 4'hf, 3, 32'ha5a5_000a);
		add_row(OP_REG_RD, 8'd9 << 2, 32'h0, 4'h0, 4, 32'h1234_5609);
		add_row(OP_REG_RD, 8'd10 << 2, 32'h0, 4'h0, 0, 32'ha5a5_000a);
		add_row(OP_STATUS_RD, CTRL_ADDR, 32'h0, 4'h0, 1, status_word(1, 1));
	endtask

	// Called on a falling edge, returns on one
	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int hold);
		logic aw_fire;
		logic w_fire;
		awaddr = addr;
		dbg_w.data = data;
		dbg_w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (awvalid || wvalid)
		begin
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			@(negedge clk);
			if (aw_fire)
				awvalid = 1'b0;
			if (w_fire)
				wvalid = 1'b0;
		end
		while (!bvalid)
			@(negedge clk);
		repeat (hold) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] addr, input int hold);
		logic ar_fire;
		araddr = addr;
		arvalid = 1'b1;
		// AR beat moves on the rising edge in between
		while (arvalid)
		begin
			ar_fire = arready;
			@(negedge clk);
			if (ar_fire)
				arvalid = 1'b0;
		end
		while (!rvalid)
			@(negedge clk);
		repeat (hold) @(negedge clk);
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic run_row(input int i);
		row_idx = 8'(i);
		row_name = op_name(t_op[i]);
		chk_read = (t_op[i] == OP_STATUS_RD || t_op[i] == OP_REG_RD);
		chk_write = (t_op[i] == OP_REG_WR);
		chk_reset = (t_op[i] == OP_EXPECT_RESET);
		exp_value = t_exp[i];
		exp_wreg = t_addr[i][6:2];
		row_start = 1'b1;
		@(negedge clk);
		row_start = 1'b0;
		case (t_op[i])
			OP_CTRL_WR, OP_REG_WR:
				bus_write(t_addr[i], t_data[i], t_strb[i], t_hold[i]);
			OP_STATUS_RD, OP_REG_RD:
				bus_read(t_addr[i], t_hold[i]);
			OP_BREAK:
			begin
				brk = 1'b1;
				@(negedge clk);
				brk = 1'b0;
			end
			default:
				while (cmd_reset !== 1'b0)
					@(negedge clk);
		endcase
		row_done = 1'b1;
		@(negedge clk);
		row_done = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		dbg_w = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		interrupt = 1'b0;
		cpu_reset = 1'b0;
		stall = 1'b1;
		brk = 1'b0;
		row_start = 1'b0;
		row_done = 1'b0;
		row_idx = '0;
		row_name = '0;
		chk_read = 1'b0;
		chk_write = 1'b0;
		chk_reset = 1'b0;
		exp_value = '0;
		exp_wreg = '0;
		cycles = 0;
		void'($urandom(55));
		for (int k = 0; k < 32; k++)
			cpu_regs[k] = $urandom;
		load_table();
		wait (rst_n === 1'b1);
		@(negedge clk);
		for (int i = 0; i < n_loaded; i++)
			run_row(i);
		$display("Rows %0d, checks %0d, errors %0d", rows, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
src/dbg_bus_pkg.sv
src/cpu_ctrl_pkg.sv
src/dbg_skid_buffer.sv
src/dbg_axil_port.sv
src/cpu_run_ctrl.sv
src/cpu_dbg_top.sv
bench/tb_clk_gen.sv
bench/tb_dbg_checker.sv
bench/tb_cpu_dbg.sv

// File: Bender.yml
package:
  name: cpu_dbg

sources:
  - src/dbg_bus_pkg.sv
  - src/cpu_ctrl_pkg.sv
  - src/dbg_skid_buffer.sv
  - src/dbg_axil_port.sv
  - src/cpu_run_ctrl.sv
  - src/cpu_dbg_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_dbg_checker.sv
      - bench/tb_cpu_dbg.sv
